//--- all.f
design/uart_frame_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/frame_tx.sv
design/frame_rx.sv
design/uart_frame_top.sv
sim/frame_checker.sv
sim/tb_uart_frame.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_uart_frame \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- sim/tb_uart_frame.sv
/*
 Testbench for uart_frame_top with CLKS_PER_BIT at 8.
 uart_rx_port is fed by loopback or by a raw byte serializer at the same bit time.
 Tasks start and end 2 ns after a rising clock edge.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_uart_frame;
	import uart_frame_pkg::*;

	localparam int bit_clks = 8;
	// 40 frames of up to 20 characters at 81 cycles each, about 2x margin
	localparam int timeout_cycles = 120000;

	logic        sys_clk;
	logic        sys_rst_n;
	frame_t      tx_frame;
	logic        tx_req;
	wire         tx_busy;
	wire         tx_done;
	frame_t      rx_frame;
	wire         rx_done;
	wire         rx_error;
	wire         uart_rx_port;
	wire         uart_tx_port;
	logic        line_sel;
	logic        raw_line;
	int          cycle_cnt;
	int unsigned seed_val;

	// 0 loopback, 1 raw serializer
	assign uart_rx_port = line_sel ? raw_line : uart_tx_port;

	uart_frame_top #(.CLKS_PER_BIT(bit_clks)) u_uart_frame_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_frame     (tx_frame),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	frame_checker u_frame_checker (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// any byte value but the mark
	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = 8'($urandom_range(0, 254));
		if (b >= frame_mark)
			b = b + 8'd1;
		return b;
	endfunction

	function automatic frame_t random_frame();
		frame_t f;
		int     i;
		f.length = len_w'($urandom_range(0, max_bytes));
		for (i = 0; i < max_bytes; i++)
			f.data[i[3:0]] = random_byte();
		return f;
	endfunction

	task automatic request_frame(input frame_t f);
		tx_frame = f;
		tx_req = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
	endtask

	// start bit, 8 data bits lsb first, stop bit
	task automatic send_raw_byte(input logic [7:0] b);
		logic [9:0] bits;
		int         i;
		bits = {1'b1, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			raw_line = bits[i];
			repeat (bit_clks) @(posedge sys_clk);
			#2;
		end
	endtask

	task automatic send_raw_frame(input frame_t f);
		int i;
		u_frame_checker.push_frame(f);
		send_raw_byte(frame_mark);
		send_raw_byte(frame_mark);
		for (i = 0; i < int'(f.length); i++)
			send_raw_byte(f.data[i[3:0]]);
		send_raw_byte(frame_mark);
		send_raw_byte(frame_mark);
	endtask

	task automatic wait_link_idle();
		while (tx_busy || u_frame_checker.pending_count() != 0) begin
			@(posedge sys_clk);
			#2;
		end
		// let the checker count the last strobe
		@(posedge sys_clk);
		#2;
	endtask

	initial begin
		frame_t f;
		int     n;
		sys_rst_n = 1'b0;
		tx_frame = '0;
		tx_req = 1'b0;
		line_sel = 1'b0;
		raw_line = 1'b1;
		seed_val = $urandom(32'h945a);
		repeat (3) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;
		repeat (2) @(posedge sys_clk);
		#2;
		u_frame_checker.finish_test("reset", 0, 0);

		for (n = 0; n < 30; n++) begin
			f = random_frame();
			u_frame_checker.push_frame(f);
			request_frame(f);
			wait_link_idle();
		end
		u_frame_checker.finish_test("loopback", 30, 0);

		// second request lands in the middle of the first frame
		f = random_frame();
		u_frame_checker.push_frame(f);
		request_frame(f);
		repeat (2 * bit_clks) @(posedge sys_clk);
		#2;
		request_frame(random_frame());
		wait_link_idle();
		u_frame_checker.finish_test("busy_request", 1, 0);

		line_sel = 1'b1;
		send_raw_byte(frame_mark);
		send_raw_byte(random_byte());
		send_raw_frame(random_frame());
		wait_link_idle();
		u_frame_checker.finish_test("lone_mark", 0, 0);

		send_raw_byte(frame_mark);
		send_raw_byte(frame_mark);
		for (n = 0; n < 3; n++)
			send_raw_byte(random_byte());
		send_raw_byte(frame_mark);
		send_raw_byte(random_byte());
		send_raw_frame(random_frame());
		wait_link_idle();
		u_frame_checker.finish_test("bad_close", 0, 1);

		send_raw_byte(frame_mark);
		send_raw_byte(frame_mark);
		for (n = 0; n <= max_bytes; n++)
			send_raw_byte(random_byte());
		send_raw_frame(random_frame());
		wait_link_idle();
		u_frame_checker.finish_test("oversize", 0, 1);

		u_frame_checker.print_counts();
		if (u_frame_checker.total_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/frame_checker.sv
/*
 Scoreboard for the framed UART link.
 Samples DUT outputs on the falling clock edge, half a cycle after they change.
 Expected frames are queued by the stimulus in the order they go on the line.
*/
`timescale 1ns/100ps
`default_nettype none

module frame_checker (
	input wire                         sys_clk,
	input wire                         sys_rst_n,
	input wire                         tx_busy,
	input wire                         tx_done,
	input wire uart_frame_pkg::frame_t rx_frame,
	input wire                         rx_done,
	input wire                         rx_error,
	input wire                         uart_tx_port
);
	import uart_frame_pkg::*;

	frame_t exp_q[$];
	int     tx_done_cnt = 0;
	int     rx_error_cnt = 0;
	int     test_errors = 0;
	int     total_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	logic   rst_d = 1'b0;
	logic   busy_d = 1'b0;

	task automatic check_val(input string name, input int exp_v, input int act_v);
		if (exp_v != act_v) begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
			test_errors++;
		end
	endtask

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	task automatic push_frame(input frame_t f);
		exp_q.push_back(f);
	endtask

	always @(posedge sys_clk)
		rst_d <= sys_rst_n;

	always @(negedge sys_clk) begin
		frame_t exp_f;
		int     i;
		// during reset and the first cycle after it
		if (!sys_rst_n || !rst_d) begin
			check_val("tx_busy", 0, int'(tx_busy));
			check_val("tx_done", 0, int'(tx_done));
			check_val("rx_done", 0, int'(rx_done));
			check_val("rx_error", 0, int'(rx_error));
			check_val("uart_tx_port", 1, int'(uart_tx_port));
		end
		if (tx_done) begin
			tx_done_cnt++;
			// busy drops in the same cycle as the done strobe
			check_val("tx_busy", 0, int'(tx_busy));
			check_val("tx_busy before tx_done", 1, int'(busy_d));
		end
		if (rx_error)
			rx_error_cnt++;
		if (rx_done) begin
			if (exp_q.size() == 0) begin
				$display("rx_done at %0t, but no frame was expected", $time);
				test_errors++;
			end else begin
				exp_f = exp_q.pop_front();
				check_val("rx_frame.length", int'(exp_f.length), int'(rx_frame.length));
				// bytes past the length are don't care
				for (i = 0; i < int'(exp_f.length); i++)
					check_val($sformatf("rx_frame.data[%0d]", i),
						int'(exp_f.data[i[3:0]]), int'(rx_frame.data[i[3:0]]));
			end
		end
		busy_d = tx_busy;
	end

	task automatic finish_test(input string name, input int exp_tx, input int exp_err);
		check_val({name, " tx_done count"}, exp_tx, tx_done_cnt);
		check_val({name, " rx_error count"}, exp_err, rx_error_cnt);
		if (exp_q.size() != 0) begin
			$display("%s: %0d expected frames were never received", name, exp_q.size());
			test_errors++;
		end
		exp_q.delete();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: FAIL with %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
		tx_done_cnt = 0;
		rx_error_cnt = 0;
	endtask

	task automatic print_counts();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
	endtask

endmodule

`default_nettype wire

//--- design/uart_frame_top.sv
/*
 Framed string link over one 8N1 UART, all on sys_clk.
 CLKS_PER_BIT is sys_clk cycles per bit, 434 gives 115200 baud at 50 MHz.
 No flow control. An unread receive frame is overwritten by the next one.
*/
`timescale 1ns/100ps
`default_nettype none

module uart_frame_top #(
	parameter int CLKS_PER_BIT = 434
) (
	input  wire                         sys_clk,
	input  wire                         sys_rst_n,
	input  wire uart_frame_pkg::frame_t tx_frame,
	input  wire                         tx_req,
	output wire                         tx_busy,
	output wire                         tx_done,
	output wire uart_frame_pkg::frame_t rx_frame,
	output wire                         rx_done,
	output wire                         rx_error,
	input  wire                         uart_rx_port,
	output wire                         uart_tx_port
);
	import uart_frame_pkg::*;

	uart_byte_t tx_byte;
	uart_byte_t rx_byte;
	logic       byte_done;

	// transmit path
	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.tx_byte   (tx_byte),
		.byte_done (byte_done)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_byte   (tx_byte),
		.line      (uart_tx_port),
		.byte_done (byte_done)
	);

	// receive path
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.line      (uart_rx_port),
		.rx_byte   (rx_byte)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_byte   (rx_byte),
		.rx_frame  (rx_frame),
		.rx_done   (rx_done),
		.rx_error  (rx_error)
	);

endmodule

`default_nettype wire

//--- design/frame_rx.sv
/*
 Receive framer: hunts for "&&", collects content up to the next "&",
 and needs a second "&" to close. rx_frame holds until the next good frame.
 Oversized or badly closed frames pulse rx_error and restart the hunt.
*/
`timescale 1ns/100ps
`default_nettype none

module frame_rx (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire uart_frame_pkg::uart_byte_t rx_byte,
	output uart_frame_pkg::frame_t     rx_frame,
	output logic                       rx_done,
	output logic                       rx_error
);
	import uart_frame_pkg::*;

	frx_state_t                state;
	logic [max_bytes-1:0][7:0] work_buf;
	logic [len_w-1:0]          byte_cnt;
	logic                      is_mark;
	logic                      buf_full;

	assign is_mark = (rx_byte.data == frame_mark);
	assign buf_full = (byte_cnt == len_w'(max_bytes));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= frx_hunt;
			byte_cnt <= '0;
			rx_done <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			rx_error <= 1'b0;
			if (rx_byte.valid) begin
				case (state)
				frx_hunt: begin
					if (is_mark)
						state <= frx_open2;
				end
				frx_open2: begin
					// a lone mark is not an error
					byte_cnt <= '0;
					state <= is_mark ? frx_body : frx_hunt;
				end
				frx_body: begin
					if (is_mark) begin
						state <= frx_close2;
					end else if (buf_full) begin
						state <= frx_hunt;
						rx_error <= 1'b1;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				default: begin
					state <= frx_hunt;
					rx_done <= is_mark;
					rx_error <= !is_mark;
				end
				endcase
			end
		end
	end

	// content store and frame handoff
	always_ff @(posedge sys_clk) begin
		if (rx_byte.valid && state == frx_body && !is_mark && !buf_full)
			work_buf[byte_cnt[len_w-2:0]] <= rx_byte.data;
		if (rx_byte.valid && state == frx_close2 && is_mark) begin
			rx_frame.data <= work_buf;
			rx_frame.length <= byte_cnt;
		end
	end

endmodule

`default_nettype wire

//--- design/frame_tx.sv
/*
 Transmit framer: sends "&&", length payload bytes, then "&&".
 A request while busy is ignored. Lengths above max_bytes are not supported.
 Payload bytes are sent as given, a "&" inside them breaks the frame.
*/
`timescale 1ns/100ps
`default_nettype none

module frame_tx (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire uart_frame_pkg::frame_t tx_frame,
	input  wire                        tx_req,
	output logic                       tx_busy,
	output logic                       tx_done,
	output uart_frame_pkg::uart_byte_t tx_byte,
	input  wire                        byte_done
);
	import uart_frame_pkg::*;

	ftx_state_t       state;
	frame_t           frame_q;
	logic [len_w-1:0] byte_cnt;
	logic             byte_valid;
	logic [7:0]       byte_data;

	assign tx_busy = (state != ftx_idle);
	assign tx_byte = '{valid: byte_valid, data: byte_data};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ftx_idle;
			byte_cnt <= '0;
			byte_valid <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			tx_done <= 1'b0;
			case (state)
			ftx_idle: begin
				byte_cnt <= '0;
				if (tx_req) begin
					state <= ftx_open1;
					byte_valid <= 1'b1;
				end
			end
			ftx_open1: begin
				if (byte_done) begin
					state <= ftx_open2;
					byte_valid <= 1'b1;
				end
			end
			ftx_open2, ftx_body: begin
				// empty payload goes straight to the closing marks
				if (byte_done) begin
					byte_valid <= 1'b1;
					if (byte_cnt == frame_q.length) begin
						state <= ftx_close1;
					end else begin
						state <= ftx_body;
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
			end
			ftx_close1: begin
				if (byte_done) begin
					state <= ftx_close2;
					byte_valid <= 1'b1;
				end
			end
			default: begin
				if (byte_done) begin
					state <= ftx_idle;
					tx_done <= 1'b1;
				end
			end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == ftx_idle && tx_req)
			frame_q <= tx_frame;
		if ((state == ftx_open2 || state == ftx_body) && byte_done
				&& byte_cnt != frame_q.length)
			byte_data <= frame_q.data[byte_cnt[len_w-2:0]];
		else
			byte_data <= frame_mark;
	end

endmodule

`default_nettype wire

//--- design/uart_rx.sv
/*
 8N1 receiver with a two-flop synchronizer and mid-bit sampling.
 A byte whose stop bit is sampled low is dropped without notice.
 No break detection and no parity.
*/
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  wire                        sys_clk,
	input  wire                        sys_rst_n,
	input  wire                        line,
	output uart_frame_pkg::uart_byte_t rx_byte
);
	import uart_frame_pkg::*;

	localparam int cnt_w = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);
	localparam logic [cnt_w-1:0] half_cnt = cnt_w'(CLKS_PER_BIT / 2 - 1);

	uart_state_t      state;
	logic [1:0]       sync;
	logic             line_s;
	logic             line_d;
	logic             fall;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             rx_valid;

	assign line_s = sync[1];
	assign fall = line_d && !line_s;
	assign rx_byte = '{valid: rx_valid, data: shift};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync <= 2'b11;
			line_d <= 1'b1;
			state <= uart_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], line};
			line_d <= line_s;
			rx_valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;

			case (state)
			uart_idle: begin
				baud_cnt <= '0;
				if (fall)
					state <= uart_start;
			end
			uart_start: begin
				// middle of the start bit, a high line here was a glitch
				if (baud_cnt == half_cnt) begin
					baud_cnt <= '0;
					bit_idx <= '0;
					state <= line_s ? uart_idle : uart_data;
				end
			end
			uart_data: begin
				if (baud_cnt == last_cnt) begin
					baud_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= uart_stop;
				end
			end
			default: begin
				if (baud_cnt == last_cnt) begin
					state <= uart_idle;
					rx_valid <= line_s;
				end
			end
			endcase
		end
	end

	// lsb arrives first and moves down to shift[0]
	always_ff @(posedge sys_clk) begin
		if (state == uart_data && baud_cnt == last_cnt)
			shift <= {line_s, shift[7:1]};
	end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
/*
 8N1 transmitter, LSB first, one stop bit.
 A byte strobe is taken only while idle and is lost during a character.
 byte_done is high in the last cycle of the stop bit.
*/
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  wire                       sys_clk,
	input  wire                       sys_rst_n,
	input  wire uart_frame_pkg::uart_byte_t tx_byte,
	output logic                      line,
	output logic                      byte_done
);
	import uart_frame_pkg::*;

	localparam int cnt_w = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);

	uart_state_t      state;
	logic [cnt_w-1:0] baud_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (baud_cnt == last_cnt);
	assign byte_done = (state == uart_stop) && bit_end;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= uart_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
			line <= 1'b1;
		end else begin
			// bit timer runs in every state but idle
			if (state == uart_idle || bit_end)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 1'b1;

			case (state)
			uart_idle: begin
				if (tx_byte.valid) begin
					state <= uart_start;
					line <= 1'b0;
				end
			end
			uart_start: begin
				if (bit_end) begin
					state <= uart_data;
					bit_idx <= '0;
					line <= shift[0];
				end
			end
			uart_data: begin
				if (bit_end) begin
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= uart_stop;
						line <= 1'b1;
					end else begin
						line <= shift[1];
					end
				end
			end
			default: begin
				if (bit_end)
					state <= uart_idle;
			end
			endcase
		end
	end

	// data bits leave from shift[0]
	always_ff @(posedge sys_clk) begin
		if (state == uart_idle && tx_byte.valid)
			shift <= tx_byte.data;
		else if (state == uart_data && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

endmodule

`default_nettype wire

//--- design/uart_frame_pkg.sv
/*
 Shared types for the framed UART link.
 A frame carries 0 to max_bytes payload bytes between "&&" marks.
 Payload bytes must never equal frame_mark because nothing is escaped.
*/
`default_nettype none

package uart_frame_pkg;

	localparam int max_bytes = 16;
	localparam int len_w = 5;
	localparam logic [7:0] frame_mark = 8'h26;

	// byte 0 of the payload sits in data[0], the low 8 bits
	typedef struct packed {
		logic [max_bytes-1:0][7:0] data;
		logic [len_w-1:0]          length;
	} frame_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} uart_byte_t;

	typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_t;

	typedef enum logic [2:0] {
		ftx_idle, ftx_open1, ftx_open2, ftx_body, ftx_close1, ftx_close2
	} ftx_state_t;

	typedef enum logic [1:0] {frx_hunt, frx_open2, frx_body, frx_close2} frx_state_t;

endpackage

`default_nettype wire
